// ==== rtl/joy_config.svh ====
`ifndef JOY_CONFIG_SVH
`define JOY_CONFIG_SVH

////////////////////
// pad timing

// clk25 cycles per snes clock half period, also per sega select step
`define JOY_PACE_CYCLES 8

// frame start to frame start
// idle gap is longer than four sega steps, so a six-button pad resets its step count
`define JOY_FRAME_CYCLES 600

// bits clocked out of the snes pad per frame, only 12 of them are buttons
`define JOY_SNES_BITS 16

////////////////////
// report link

`define JOY_REPORT_CREDITS 4 // consumer queue depth

`endif

// ==== rtl/joy_pkg.sv ====
package joy_pkg;

	// one bit per button, 1 = pressed
	typedef logic [11:0] buttons_t;

	////////////////////
	// snes order, bit 0 is shifted out first
	localparam int SNES_B      = 0;
	localparam int SNES_Y      = 1;
	localparam int SNES_SELECT = 2;
	localparam int SNES_START  = 3;
	localparam int SNES_UP     = 4;
	localparam int SNES_DOWN   = 5;
	localparam int SNES_LEFT   = 6;
	localparam int SNES_RIGHT  = 7;
	localparam int SNES_A      = 8;
	localparam int SNES_X      = 9;
	localparam int SNES_L      = 10;
	localparam int SNES_R      = 11;

	////////////////////
	// mega drive order
	localparam int SEGA_UP    = 0;
	localparam int SEGA_DOWN  = 1;
	localparam int SEGA_LEFT  = 2;
	localparam int SEGA_RIGHT = 3;
	localparam int SEGA_B     = 4;
	localparam int SEGA_C     = 5;
	localparam int SEGA_A     = 6;
	localparam int SEGA_START = 7;
	localparam int SEGA_Z     = 8; // upper four only on six-button pads
	localparam int SEGA_Y     = 9;
	localparam int SEGA_X     = 10;
	localparam int SEGA_MODE  = 11;

endpackage

// ==== rtl/report_pkg.sv ====
package report_pkg;

	// which pad a report came from
	typedef enum logic
	{
		SRC_SNES = 1'b0,
		SRC_SEGA = 1'b1
	} src_t;

	// sender credit count, 0 up to JOY_REPORT_CREDITS
	typedef logic [2:0] credit_t;

endpackage

// ==== rtl/snes_pad_reader.sv ====
`timescale 1ns/1ps
`include "joy_config.svh"

module snes_pad_reader
(
	input  logic              clk25,
	input  logic              rst_n_i,
	input  logic              scan_en_i,
	input  logic              snes_data_i,
	output logic              snes_latch_o,
	output logic              snes_clk_o,
	output joy_pkg::buttons_t buttons_o,
	output logic              done_o
);

	localparam int FRAME_W = $clog2(`JOY_FRAME_CYCLES);
	localparam int PACE_W  = $clog2(2 * `JOY_PACE_CYCLES);
	localparam int BIT_W   = $clog2(`JOY_SNES_BITS);

	localparam logic [FRAME_W-1:0] FRAME_LAST = FRAME_W'(`JOY_FRAME_CYCLES - 1);
	localparam logic [PACE_W-1:0]  PACE_LAST  = PACE_W'(`JOY_PACE_CYCLES - 1);
	localparam logic [PACE_W-1:0]  LATCH_LAST = PACE_W'(2 * `JOY_PACE_CYCLES - 1);
	localparam logic [BIT_W-1:0]   BIT_LAST   = BIT_W'(`JOY_SNES_BITS - 1);

	typedef enum logic [1:0] {PH_IDLE, PH_LATCH, PH_LOW, PH_HIGH} phase_t;

	logic [FRAME_W-1:0]        frame_cnt_q;
	logic [PACE_W-1:0]         pace_q;
	logic [BIT_W-1:0]          bit_q;
	phase_t                    phase_q;
	logic [`JOY_SNES_BITS-1:0] shift_q;
	logic                      frame_start;
	logic                      sample_en;
	logic                      frame_end;

	assign frame_start = (frame_cnt_q == '0) && scan_en_i;
	assign sample_en   = (phase_q == PH_LOW) && (pace_q == '0); // last cycle of low phase
	assign frame_end   = (phase_q == PH_HIGH) && (pace_q == '0) && (bit_q == BIT_LAST);

	////////////////////
	// frame timer

	always_ff @(posedge clk25)
	begin
		if (!rst_n_i)
			frame_cnt_q <= '0;
		else if (frame_start)
			frame_cnt_q <= FRAME_LAST;
		else if (frame_cnt_q != '0)
			frame_cnt_q <= frame_cnt_q - 1'b1;
	end

	////////////////////
	// latch and clock phases

	always_ff @(posedge clk25)
	begin
		if (!rst_n_i)
		begin
			phase_q      <= PH_IDLE;
			pace_q       <= '0;
			bit_q        <= '0;
			snes_latch_o <= 1'b0;
			snes_clk_o   <= 1'b0;
			done_o       <= 1'b0;
		end
		else
		begin
			done_o <= 1'b0;
			if (pace_q != '0)
				pace_q <= pace_q - 1'b1;
			case (phase_q)
			PH_IDLE:
				if (frame_start)
				begin
					phase_q      <= PH_LATCH;
					pace_q       <= LATCH_LAST;
					snes_latch_o <= 1'b1;
				end
			PH_LATCH:
				if (pace_q == '0)
				begin
					phase_q      <= PH_LOW;
					pace_q       <= PACE_LAST;
					bit_q        <= '0;
					snes_latch_o <= 1'b0; // bit 0 now on the data pin
				end
			PH_LOW:
				if (pace_q == '0)
				begin
					phase_q    <= PH_HIGH;
					pace_q     <= PACE_LAST;
					snes_clk_o <= 1'b1;
				end
			PH_HIGH:
				if (pace_q == '0)
				begin
					pace_q     <= PACE_LAST;
					snes_clk_o <= 1'b0;
					if (bit_q == BIT_LAST)
					begin
						phase_q <= PH_IDLE;
						done_o  <= 1'b1;
					end
					else
					begin
						phase_q <= PH_LOW;
						bit_q   <= bit_q + 1'b1;
					end
				end
			default: phase_q <= PH_IDLE;
			endcase
		end
	end

	// data pin is active low, first bit ends up at bit 0
	always_ff @(posedge clk25)
	begin
		if (sample_en)
			shift_q <= {~snes_data_i, shift_q[`JOY_SNES_BITS-1:1]};
		if (frame_end)
			buttons_o <= shift_q[joy_pkg::SNES_R:joy_pkg::SNES_B];
	end

	a_latch_clk_excl: assert property (@(posedge clk25) disable iff (!rst_n_i)
		!(snes_latch_o && snes_clk_o));

endmodule

// ==== rtl/sega_pad_reader.sv ====
`timescale 1ns/1ps
`include "joy_config.svh"

module sega_pad_reader
(
	input  logic              clk25,
	input  logic              rst_n_i,
	input  logic              scan_en_i,
	input  logic              sega_up_i,
	input  logic              sega_down_i,
	input  logic              sega_left_i,
	input  logic              sega_right_i,
	input  logic              sega_p6_i,
	input  logic              sega_p9_i,
	output logic              sega_select_o,
	output joy_pkg::buttons_t buttons_o,
	output logic              done_o
);

	localparam int FRAME_W = $clog2(`JOY_FRAME_CYCLES);
	localparam int PACE_W  = $clog2(`JOY_PACE_CYCLES);

	localparam logic [FRAME_W-1:0] FRAME_LAST = FRAME_W'(`JOY_FRAME_CYCLES - 1);
	localparam logic [PACE_W-1:0]  PACE_LAST  = PACE_W'(`JOY_PACE_CYCLES - 1);
	localparam logic [3:0]         STEP_LAST  = 4'd8;

	logic [FRAME_W-1:0] frame_cnt_q;
	logic [PACE_W-1:0]  pace_q;
	logic [3:0]         step_q; // 0 between frames, 1..8 in a frame
	logic               six_q;
	joy_pkg::buttons_t  work_q;
	logic               frame_start;
	logic               step_end;

	assign frame_start = (frame_cnt_q == '0) && scan_en_i;
	assign step_end    = (step_q != '0) && (pace_q == '0);

	////////////////////
	// frame timer

	always_ff @(posedge clk25)
	begin
		if (!rst_n_i)
			frame_cnt_q <= '0;
		else if (frame_start)
			frame_cnt_q <= FRAME_LAST;
		else if (frame_cnt_q != '0)
			frame_cnt_q <= frame_cnt_q - 1'b1;
	end

	////////////////////
	// select sequencer

	always_ff @(posedge clk25)
	begin
		if (!rst_n_i)
		begin
			step_q        <= '0;
			pace_q        <= '0;
			sega_select_o <= 1'b1;
			done_o        <= 1'b0;
		end
		else
		begin
			done_o <= 1'b0;
			if (pace_q != '0)
				pace_q <= pace_q - 1'b1;
			if (step_q == '0)
			begin
				if (frame_start)
				begin
					step_q <= 4'd1; // step 1 keeps select high
					pace_q <= PACE_LAST;
				end
			end
			else if (pace_q == '0)
			begin
				pace_q <= PACE_LAST;
				if (step_q == STEP_LAST)
				begin
					step_q        <= '0;
					sega_select_o <= 1'b1;
					done_o        <= 1'b1;
				end
				else
				begin
					step_q        <= step_q + 1'b1;
					sega_select_o <= ~step_q[0]; // odd steps high, even steps low
				end
			end
		end
	end

	// pins are active low
	always_ff @(posedge clk25)
	begin
		if (step_end)
		begin
			case (step_q)
			4'd1:
			begin
				work_q[joy_pkg::SEGA_UP]    <= ~sega_up_i;
				work_q[joy_pkg::SEGA_DOWN]  <= ~sega_down_i;
				work_q[joy_pkg::SEGA_LEFT]  <= ~sega_left_i;
				work_q[joy_pkg::SEGA_RIGHT] <= ~sega_right_i;
				work_q[joy_pkg::SEGA_B]     <= ~sega_p6_i;
				work_q[joy_pkg::SEGA_C]     <= ~sega_p9_i;
			end
			4'd2:
			begin
				work_q[joy_pkg::SEGA_A]     <= ~sega_p6_i;
				work_q[joy_pkg::SEGA_START] <= ~sega_p9_i;
			end
			// all directions low here only on a six-button pad
			4'd6: six_q <= ~(sega_up_i | sega_down_i | sega_left_i | sega_right_i);
			4'd7:
			begin
				work_q[joy_pkg::SEGA_Z]    <= six_q & ~sega_up_i;
				work_q[joy_pkg::SEGA_Y]    <= six_q & ~sega_down_i;
				work_q[joy_pkg::SEGA_X]    <= six_q & ~sega_left_i;
				work_q[joy_pkg::SEGA_MODE] <= six_q & ~sega_right_i;
			end
			default: ;
			endcase
		end
		if (step_end && step_q == STEP_LAST)
			buttons_o <= work_q;
	end

	a_select_idle_high: assert property (@(posedge clk25) disable iff (!rst_n_i)
		(step_q == '0) |-> sega_select_o);

endmodule

// ==== rtl/pad_report_tx.sv ====
`timescale 1ns/1ps
`include "joy_config.svh"

module pad_report_tx
(
	input  logic              clk25,
	input  logic              rst_n_i,
	input  joy_pkg::buttons_t snes_buttons_i,
	input  logic              snes_done_i,
	input  joy_pkg::buttons_t sega_buttons_i,
	input  logic              sega_done_i,
	input  logic              credit_i,
	output logic              report_valid_o,
	output report_pkg::src_t  report_src_o,
	output joy_pkg::buttons_t report_buttons_o
);

	localparam report_pkg::credit_t CREDITS_INIT = report_pkg::credit_t'(`JOY_REPORT_CREDITS);

	joy_pkg::buttons_t   last_snes_q;
	joy_pkg::buttons_t   last_sega_q;
	joy_pkg::buttons_t   slot_snes_q;
	joy_pkg::buttons_t   slot_sega_q;
	joy_pkg::buttons_t   ref_snes;
	joy_pkg::buttons_t   ref_sega;
	logic                pend_snes_q;
	logic                pend_sega_q;
	logic                have_credit;
	logic                issue_snes;
	logic                issue_sega;
	report_pkg::credit_t credit_q;

	assign have_credit = (credit_q != '0);
	assign issue_snes  = pend_snes_q && have_credit;
	assign issue_sega  = pend_sega_q && !pend_snes_q && have_credit; // snes first

	// last-sent value as it stands after this cycle
	assign ref_snes = issue_snes ? slot_snes_q : last_snes_q;
	assign ref_sega = issue_sega ? slot_sega_q : last_sega_q;

	////////////////////
	// pending slots

	always_ff @(posedge clk25)
	begin
		if (!rst_n_i)
		begin
			pend_snes_q <= 1'b0;
			pend_sega_q <= 1'b0;
			last_snes_q <= '0;
			last_sega_q <= '0;
		end
		else
		begin
			if (issue_snes)
			begin
				pend_snes_q <= 1'b0;
				last_snes_q <= slot_snes_q;
			end
			if (issue_sega)
			begin
				pend_sega_q <= 1'b0;
				last_sega_q <= slot_sega_q;
			end
			// a frame back at the sent value cancels a stale slot
			if (snes_done_i)
				pend_snes_q <= (snes_buttons_i != ref_snes);
			if (sega_done_i)
				pend_sega_q <= (sega_buttons_i != ref_sega);
		end
	end

	always_ff @(posedge clk25)
	begin
		if (snes_done_i)
			slot_snes_q <= snes_buttons_i; // newest wins
		if (sega_done_i)
			slot_sega_q <= sega_buttons_i;
	end

	////////////////////
	// credits

	always_ff @(posedge clk25)
	begin
		if (!rst_n_i)
			credit_q <= CREDITS_INIT;
		else
		begin
			case ({report_valid_o, credit_i})
			2'b10:   credit_q <= credit_q - 1'b1;
			2'b01:   credit_q <= credit_q + 1'b1;
			default: ;
			endcase
		end
	end

	assign report_valid_o   = issue_snes || issue_sega;
	assign report_src_o     = issue_snes ? report_pkg::SRC_SNES : report_pkg::SRC_SEGA;
	assign report_buttons_o = issue_snes ? slot_snes_q : slot_sega_q;

	// consumer must not hand back more than it got
	a_credit_bound: assert property (@(posedge clk25) disable iff (!rst_n_i)
		credit_q <= CREDITS_INIT);

endmodule

// ==== rtl/pad_scan_top.sv ====
`timescale 1ns/1ps

module pad_scan_top
(
	input  logic              clk25,
	input  logic              rst_n_i,
	input  logic              scan_en_i,
	// snes connector
	input  logic              snes_data_i,
	output logic              snes_latch_o,
	output logic              snes_clk_o,
	// mega drive connector
	input  logic              sega_up_i,
	input  logic              sega_down_i,
	input  logic              sega_left_i,
	input  logic              sega_right_i,
	input  logic              sega_p6_i,
	input  logic              sega_p9_i,
	output logic              sega_select_o,
	// report link
	input  logic              credit_i,
	output logic              report_valid_o,
	output report_pkg::src_t  report_src_o,
	output joy_pkg::buttons_t report_buttons_o
);

	joy_pkg::buttons_t snes_buttons;
	joy_pkg::buttons_t sega_buttons;
	logic              snes_done;
	logic              sega_done;

	snes_pad_reader snes_pad_reader_i
	(
		.clk25        (clk25),
		.rst_n_i      (rst_n_i),
		.scan_en_i    (scan_en_i),
		.snes_data_i  (snes_data_i),
		.snes_latch_o (snes_latch_o),
		.snes_clk_o   (snes_clk_o),
		.buttons_o    (snes_buttons),
		.done_o       (snes_done)
	);

	sega_pad_reader sega_pad_reader_i
	(
		.clk25         (clk25),
		.rst_n_i       (rst_n_i),
		.scan_en_i     (scan_en_i),
		.sega_up_i     (sega_up_i),
		.sega_down_i   (sega_down_i),
		.sega_left_i   (sega_left_i),
		.sega_right_i  (sega_right_i),
		.sega_p6_i     (sega_p6_i),
		.sega_p9_i     (sega_p9_i),
		.sega_select_o (sega_select_o),
		.buttons_o     (sega_buttons),
		.done_o        (sega_done)
	);

	pad_report_tx pad_report_tx_i
	(
		.clk25            (clk25),
		.rst_n_i          (rst_n_i),
		.snes_buttons_i   (snes_buttons),
		.snes_done_i      (snes_done),
		.sega_buttons_i   (sega_buttons),
		.sega_done_i      (sega_done),
		.credit_i         (credit_i),
		.report_valid_o   (report_valid_o),
		.report_src_o     (report_src_o),
		.report_buttons_o (report_buttons_o)
	);

endmodule

// ==== bench/pad_scan_tb.sv ====
`timescale 1ns/1ps
`include "joy_config.svh"

module pad_scan_tb;

	localparam int     CLK_PERIOD = 100;
	localparam int     FRAME      = `JOY_FRAME_CYCLES;
	localparam int     PAIRS      = 20;
	localparam int     TESTS      = 5 + PAIRS; // each random pair counted as a test
	localparam longint WATCHDOG   = longint'(TESTS) * 8 * FRAME * CLK_PERIOD;

	logic              clk25 = 1'b0;
	logic              rst_n_i;
	logic              scan_en_i;
	logic              snes_data_i;
	logic              snes_latch_o;
	logic              snes_clk_o;
	logic              sega_up_i;
	logic              sega_down_i;
	logic              sega_left_i;
	logic              sega_right_i;
	logic              sega_p6_i;
	logic              sega_p9_i;
	logic              sega_select_o;
	logic              credit_i;
	logic              report_valid_o;
	report_pkg::src_t  report_src_o;
	joy_pkg::buttons_t report_buttons_o;

	// pad model state
	logic [15:0]       snes_pat;
	logic [15:0]       snes_sr;
	logic              snes_clk_d;
	joy_pkg::buttons_t sega_pat;
	logic              six_btn;
	logic              sel_d;
	int                sel_edges;
	int                sel_high;

	// consumer state
	logic              hold_credit;
	logic [1:0]        ret_pipe;
	int                owed;
	report_pkg::src_t  rep_src[$];
	joy_pkg::buttons_t rep_btn[$];
	int                errors;
	int                checks;

	pad_scan_top pad_scan_top_i
	(
		.clk25            (clk25),
		.rst_n_i          (rst_n_i),
		.scan_en_i        (scan_en_i),
		.snes_data_i      (snes_data_i),
		.snes_latch_o     (snes_latch_o),
		.snes_clk_o       (snes_clk_o),
		.sega_up_i        (sega_up_i),
		.sega_down_i      (sega_down_i),
		.sega_left_i      (sega_left_i),
		.sega_right_i     (sega_right_i),
		.sega_p6_i        (sega_p6_i),
		.sega_p9_i        (sega_p9_i),
		.sega_select_o    (sega_select_o),
		.credit_i         (credit_i),
		.report_valid_o   (report_valid_o),
		.report_src_o     (report_src_o),
		.report_buttons_o (report_buttons_o)
	);

	always #(CLK_PERIOD / 2) clk25 = ~clk25;

	////////////////////
	// pad models

	assign snes_data_i = snes_sr[0];

	always @(negedge clk25)
	begin
		if (snes_latch_o)
			snes_sr <= {4'hF, ~snes_pat[11:0]}; // released after the 12 buttons
		else if (snes_clk_o && !snes_clk_d)
			snes_sr <= {1'b1, snes_sr[15:1]};
		snes_clk_d <= snes_clk_o;
	end

	task automatic drive_sega_pins(input int edges);
		logic sel_low;
		sel_low = edges[0];
		if (edges == 6 && six_btn)
			{sega_right_i, sega_left_i, sega_down_i, sega_up_i} = ~sega_pat[11:8];
		else if (edges == 5 && six_btn)
			{sega_right_i, sega_left_i, sega_down_i, sega_up_i} = 4'b0000; // six-button id
		else if (sel_low)
			{sega_right_i, sega_left_i, sega_down_i, sega_up_i} = {2'b00, ~sega_pat[1:0]};
		else
			{sega_right_i, sega_left_i, sega_down_i, sega_up_i} = ~sega_pat[3:0];
		sega_p6_i = sel_low ? ~sega_pat[joy_pkg::SEGA_A] : ~sega_pat[joy_pkg::SEGA_B];
		sega_p9_i = sel_low ? ~sega_pat[joy_pkg::SEGA_START] : ~sega_pat[joy_pkg::SEGA_C];
	endtask

	always @(negedge clk25)
	begin
		if (sega_select_o != sel_d)
		begin
			sel_edges = sel_edges + 1;
			sel_high  = 0;
		end
		else if (sega_select_o)
			sel_high = sel_high + 1;
		if (sel_high > 4 * `JOY_PACE_CYCLES)
			sel_edges = 0; // long high, pad restarts its step count
		sel_d = sega_select_o;
		drive_sega_pins(sel_edges);
	end

	////////////////////
	// consumer

	always @(negedge clk25)
	begin
		if (report_valid_o)
		begin
			rep_src.push_back(report_src_o);
			rep_btn.push_back(report_buttons_o);
		end
		if (ret_pipe[1])
			owed = owed + 1;
		ret_pipe = {ret_pipe[0], report_valid_o};
		if (!hold_credit && owed > 0)
		begin
			credit_i = 1'b1;
			owed     = owed - 1;
		end
		else
			credit_i = 1'b0;
	end

	////////////////////
	// helpers

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("ERROR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("%s", what);
	endtask

	task automatic clear_reports();
		rep_src.delete();
		rep_btn.delete();
	endtask

	task automatic wait_reports(input int n);
		int cyc;
		cyc = 0;
		while (rep_src.size() < n && cyc < 3 * FRAME)
		begin
			@(negedge clk25);
			cyc++;
		end
		if (rep_src.size() < n)
			report_failure($sformatf("only %0d of %0d reports arrived", rep_src.size(), n));
	endtask

	task automatic expect_report(input report_pkg::src_t src, input joy_pkg::buttons_t btn);
		if (rep_src.size() == 0)
			report_failure("an expected report never arrived");
		else
		begin
			check_value("report_src_o", src, rep_src.pop_front());
			check_value("report_buttons_o", btn, rep_btn.pop_front());
		end
	endtask

	// a point just after a sega frame, snes latch long done
	task automatic wait_frame_gap();
		@(negedge sega_select_o);
		repeat (10 * `JOY_PACE_CYCLES) @(negedge clk25);
	endtask

	task automatic watch_idle(input int cycles, input logic whole);
		for (int i = 0; i < cycles; i++)
		begin
			@(negedge clk25);
			check_value("report_valid_o", 0, report_valid_o);
			if (whole || (i % FRAME) > FRAME / 2)
			begin
				check_value("snes_latch_o", 0, snes_latch_o);
				check_value("snes_clk_o", 0, snes_clk_o);
				check_value("sega_select_o", 1, sega_select_o);
			end
		end
	endtask

	////////////////////
	// directed tests

	task automatic idle_after_reset();
		watch_idle(3 * FRAME, 1'b0);
		check_value("report count", 0, rep_src.size());
	endtask

	task automatic snes_change();
		clear_reports();
		wait_frame_gap();
		snes_pat = 16'h3A5C; // top nibble is never clocked in
		wait_reports(1);
		expect_report(report_pkg::SRC_SNES, snes_pat[11:0]);
		repeat (2 * FRAME) @(negedge clk25);
		check_value("report count", 0, rep_src.size());
	endtask

	task automatic sega_six_three();
		clear_reports();
		wait_frame_gap();
		sega_pat = 12'hF2D;
		wait_reports(1);
		expect_report(report_pkg::SRC_SEGA, sega_pat);
		wait_frame_gap();
		six_btn = 1'b0;
		wait_reports(1);
		expect_report(report_pkg::SRC_SEGA, {4'h0, sega_pat[7:0]}); // no Z Y X Mode
		wait_frame_gap();
		six_btn = 1'b1;
		wait_reports(1);
		expect_report(report_pkg::SRC_SEGA, sega_pat);
		repeat (2 * FRAME) @(negedge clk25);
		check_value("report count", 0, rep_src.size());
	endtask

	task automatic credit_backpressure();
		clear_reports();
		hold_credit = 1'b1;
		for (int i = 0; i < 5; i++)
		begin
			wait_frame_gap();
			snes_pat = i[0] ? 16'h0123 : 16'h0456;
			sega_pat = i[0] ? 12'h0C3 : 12'h93C;
		end
		repeat (2 * FRAME) @(negedge clk25);
		check_value("reports under hold", `JOY_REPORT_CREDITS, rep_src.size());
		clear_reports();
		hold_credit = 1'b0;
		wait_reports(2);
		expect_report(report_pkg::SRC_SNES, snes_pat[11:0]); // snes wins the tie
		expect_report(report_pkg::SRC_SEGA, sega_pat);
		repeat (2 * FRAME) @(negedge clk25);
		check_value("report count", 0, rep_src.size());
	endtask

	task automatic scan_disable();
		clear_reports();
		wait_frame_gap();
		scan_en_i = 1'b0;
		repeat (FRAME) @(negedge clk25); // let the running snes frame end
		snes_pat = 16'hF0F0;
		sega_pat = 12'h5A1;
		watch_idle(3 * FRAME, 1'b1);
		scan_en_i = 1'b1;
		wait_reports(2);
		expect_report(report_pkg::SRC_SEGA, sega_pat); // sega frame is shorter
		expect_report(report_pkg::SRC_SNES, snes_pat[11:0]);
	endtask

	task automatic random_pairs();
		joy_pkg::buttons_t prev_snes;
		joy_pkg::buttons_t prev_sega;
		wait_frame_gap();
		for (int i = 0; i < PAIRS; i++)
		begin
			prev_snes = snes_pat[11:0];
			prev_sega = sega_pat;
			clear_reports();
			// now and then a value repeats
			if ($urandom_range(3) != 0)
				snes_pat = 16'($urandom);
			if ($urandom_range(3) != 0)
				sega_pat = 12'($urandom);
			wait_frame_gap();
			wait_frame_gap();
			if (sega_pat != prev_sega)
				expect_report(report_pkg::SRC_SEGA, sega_pat);
			if (snes_pat[11:0] != prev_snes)
				expect_report(report_pkg::SRC_SNES, snes_pat[11:0]);
			check_value("report count", 0, rep_src.size());
		end
	endtask

	////////////////////
	// main sequence

	initial
	begin
		void'($urandom(20006));
		errors       = 0;
		checks       = 0;
		rst_n_i      = 1'b0;
		scan_en_i    = 1'b1;
		credit_i     = 1'b0;
		hold_credit  = 1'b0;
		ret_pipe     = 2'b00;
		owed         = 0;
		snes_pat     = '0;
		snes_sr      = '1;
		snes_clk_d   = 1'b0;
		sega_pat     = '0;
		six_btn      = 1'b1;
		sel_d        = 1'b1;
		sel_edges    = 0;
		sel_high     = 0;
		sega_up_i    = 1'b1;
		sega_down_i  = 1'b1;
		sega_left_i  = 1'b1;
		sega_right_i = 1'b1;
		sega_p6_i    = 1'b1;
		sega_p9_i    = 1'b1;
		repeat (4) @(negedge clk25);
		rst_n_i = 1'b1;

		idle_after_reset();
		snes_change();
		sega_six_three();
		credit_backpressure();
		scan_disable();
		random_pairs();

		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// watchdog
	initial
	begin
		#(WATCHDOG);
		$display("timeout, the tests did not finish in time, %0d errors so far", errors);
		$display("Test failed");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/joy_pkg.sv
rtl/report_pkg.sv
rtl/snes_pad_reader.sv
rtl/sega_pad_reader.sv
rtl/pad_report_tx.sv
rtl/pad_scan_top.sv
bench/pad_scan_tb.sv

// ==== Bender.yml ====
package:
  name: pad_scan

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/joy_pkg.sv
      - rtl/report_pkg.sv
      - rtl/snes_pad_reader.sv
      - rtl/sega_pad_reader.sv
      - rtl/pad_report_tx.sv
      - rtl/pad_scan_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - bench/pad_scan_tb.sv
